//--- source/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// --------------------
// Clocking
// --------------------

// Clock cycles per microsecond tick
`define SOC_CLK_MHZ 4

// --------------------
// Address map
// --------------------

// SRAM size in 32-bit words
`define SOC_SRAM_DEPTH 1024

`define SOC_SRAM_BASE 32'h0000_0000
`define SOC_TIMER_BASE 32'h4000_0000

// Upper bits that pick the target region
`define SOC_REGION_MASK 32'hE000_0000

// Timer register byte offsets
`define SOC_TIMER_CTRL 8'h00
`define SOC_TIMER_MTIME 8'h08
`define SOC_TIMER_MTIMEH 8'h0C
`define SOC_TIMER_MTIMECMP 8'h10
`define SOC_TIMER_MTIMECMPH 8'h14

`endif

//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

    // --------------------
    // Wishbone vector types
    // --------------------

    // Byte address as seen on wb_adr
    typedef logic [31:0] bus_addr_t;

    // One data word, read or write
    typedef logic [31:0] bus_data_t;

    // One select bit per byte lane of bus_data_t
    typedef logic [3:0] bus_sel_t;

endpackage

//--- source/soc_timer_pkg.sv
`include "soc_params.svh"

package soc_timer_pkg;

    // Machine time, counted in microseconds
    typedef logic [63:0] mtime_t;

    // Prescaler width, one spare bit so a clock rate of 1 still fits
    localparam int unsigned PRESCALE_W = $clog2(`SOC_CLK_MHZ + 1);

    typedef logic [PRESCALE_W-1:0] prescale_t;

endpackage

//--- source/soc_bus_decode.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_bus_decode
    import soc_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  bus_addr_t adr,
    output logic      sram_stb,
    output logic      timer_stb,
    input  bus_data_t sram_dat_r,
    input  bus_data_t timer_dat_r,
    input  logic      sram_ack,
    input  logic      timer_ack,
    output bus_data_t dat_r,
    output logic      ack,
    output logic      err
);

    logic sram_hit;
    logic timer_hit;
    logic unmapped_req;

    // --------------------
    // Region decode
    // --------------------

    assign sram_hit  = (adr & `SOC_REGION_MASK) == (`SOC_SRAM_BASE & `SOC_REGION_MASK);
    assign timer_hit = (adr & `SOC_REGION_MASK) == (`SOC_TIMER_BASE & `SOC_REGION_MASK);

    assign sram_stb  = stb && sram_hit;
    assign timer_stb = stb && timer_hit;

    // Nobody owns this address, answer locally
    assign unmapped_req = cyc && stb && !sram_hit && !timer_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else begin
            err <= unmapped_req && !err;
        end
    end

    // --------------------
    // Response return
    // --------------------

    // Host holds adr until the response, so the region still selects it
    assign ack = (sram_hit && sram_ack) || (timer_hit && timer_ack);

    always_comb begin
        dat_r = '0;
        if (sram_hit) begin
            dat_r = sram_dat_r;
        end else if (timer_hit) begin
            dat_r = timer_dat_r;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(sram_stb && timer_stb));

    // Target acks and the local error never collide
    assert property (@(posedge clk) disable iff (!rst_n) !(ack && err));

endmodule

//--- source/soc_sram.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_sram
    import soc_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_addr_t adr,
    input  bus_data_t dat_w,
    input  bus_sel_t  sel,
    output bus_data_t dat_r,
    output logic      ack
);

    localparam int unsigned IDX_W = $clog2(`SOC_SRAM_DEPTH);

    bus_data_t        mem [`SOC_SRAM_DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic             access;

    // New request only, not the tail of one already answered
    assign access = cyc && stb && !ack;

    // Word address wraps at the array depth
    assign word_idx = IDX_W'(adr[31:2] % `SOC_SRAM_DEPTH);

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk) begin
        if (access && we) begin
            for (int lane = 0; lane < $bits(bus_sel_t); lane++) begin
                if (sel[lane]) begin
                    mem[word_idx][8*lane +: 8] <= dat_w[8*lane +: 8];
                end
            end
        end
        if (access && !we) begin
            dat_r <= mem[word_idx];
        end
    end

    // --------------------
    // Response
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack);

endmodule

//--- source/timer_tick_gen.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module timer_tick_gen
    import soc_timer_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam prescale_t RELOAD = prescale_t'(`SOC_CLK_MHZ - 1);

    prescale_t count;

    // Down-counter, one tick each time it wraps through zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= RELOAD;
            tick  <= 1'b0;
        end else begin
            if (count == '0) begin
                count <= RELOAD;
            end else begin
                count <= count - 1'b1;
            end
            tick <= (count == '0);
        end
    end

endmodule

//--- source/riscv_timer.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module riscv_timer
    import soc_bus_pkg::*;
    import soc_timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  bus_addr_t adr,
    input  bus_data_t dat_w,
    input  bus_sel_t  sel,
    output bus_data_t dat_r,
    output logic      ack,
    input  logic      tick,
    input  logic      dbg_halt,
    output logic      irq
);

    logic       access;
    logic       wr_en;
    logic [7:0] reg_offset;
    logic       ctrl_en;
    logic       count_en;
    mtime_t     mtime;
    mtime_t     mtimecmp;
    bus_data_t  rd_data;

    // Replace only the selected byte lanes of a register word
    function automatic bus_data_t merge_bytes(
        input bus_data_t old_val,
        input bus_data_t new_val,
        input bus_sel_t  lanes
    );
        bus_data_t result;
        result = old_val;
        for (int i = 0; i < $bits(bus_sel_t); i++) begin
            if (lanes[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign access     = cyc && stb && !ack;
    assign wr_en      = access && we;
    assign reg_offset = {adr[7:2], 2'b00};

    // Frozen while the hart sits in debug halt
    assign count_en = tick && ctrl_en && !dbg_halt;

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_en  <= 1'b0;
            mtimecmp <= '1;
        end else if (wr_en) begin
            if (reg_offset == `SOC_TIMER_CTRL && sel[0]) begin
                ctrl_en <= dat_w[0];
            end
            if (reg_offset == `SOC_TIMER_MTIMECMP) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], dat_w, sel);
            end
            if (reg_offset == `SOC_TIMER_MTIMECMPH) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], dat_w, sel);
            end
        end
    end

    // Bus write wins over the tick increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && reg_offset == `SOC_TIMER_MTIME) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], dat_w, sel);
        end else if (wr_en && reg_offset == `SOC_TIMER_MTIMEH) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], dat_w, sel);
        end else if (count_en) begin
            mtime <= mtime + 1'b1;
        end
    end

    assign irq = (mtime >= mtimecmp);

    // --------------------
    // Bus response
    // --------------------

    always_comb begin
        case (reg_offset)
            `SOC_TIMER_CTRL:      rd_data = {31'b0, ctrl_en};
            `SOC_TIMER_MTIME:     rd_data = mtime[31:0];
            `SOC_TIMER_MTIMEH:    rd_data = mtime[63:32];
            `SOC_TIMER_MTIMECMP:  rd_data = mtimecmp[31:0];
            `SOC_TIMER_MTIMECMPH: rd_data = mtimecmp[63:32];
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access && !we) begin
            dat_r <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) ack |-> $past(cyc && stb));

endmodule

//--- source/soc_periph_top.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_periph_top
    import soc_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  bus_addr_t wb_adr,
    input  bus_data_t wb_dat_w,
    input  bus_sel_t  wb_sel,
    output bus_data_t wb_dat_r,
    output logic      wb_ack,
    output logic      wb_err,
    input  logic      dbg_halt,
    output logic      timer_irq
);

    logic      sram_stb;
    logic      timer_stb;
    bus_data_t sram_dat_r;
    bus_data_t timer_dat_r;
    logic      sram_ack;
    logic      timer_ack;
    logic      tick;

    // --------------------
    // Bus fabric
    // --------------------

    soc_bus_decode i_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (wb_cyc),
        .stb        (wb_stb),
        .adr        (wb_adr),
        .sram_stb   (sram_stb),
        .timer_stb  (timer_stb),
        .sram_dat_r (sram_dat_r),
        .timer_dat_r(timer_dat_r),
        .sram_ack   (sram_ack),
        .timer_ack  (timer_ack),
        .dat_r      (wb_dat_r),
        .ack        (wb_ack),
        .err        (wb_err)
    );

    // --------------------
    // Memory and timer
    // --------------------

    soc_sram i_sram (
        .clk  (clk),
        .rst_n(rst_n),
        .cyc  (wb_cyc),
        .stb  (sram_stb),
        .we   (wb_we),
        .adr  (wb_adr),
        .dat_w(wb_dat_w),
        .sel  (wb_sel),
        .dat_r(sram_dat_r),
        .ack  (sram_ack)
    );

    // Microsecond timebase
    timer_tick_gen i_tick (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    riscv_timer i_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .cyc     (wb_cyc),
        .stb     (timer_stb),
        .we      (wb_we),
        .adr     (wb_adr),
        .dat_w   (wb_dat_w),
        .sel     (wb_sel),
        .dat_r   (timer_dat_r),
        .ack     (timer_ack),
        .tick    (tick),
        .dbg_halt(dbg_halt),
        .irq     (timer_irq)
    );

endmodule

//--- bench/tb_soc_periph_top.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module tb_soc_periph_top
    import soc_bus_pkg::*;
();

    localparam int OP_IDLE = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_READ = 2;

    // Read data compare modes
    localparam int M_NONE = 0;
    localparam int M_EXACT = 1;
    localparam int M_RANGE = 2;
    localparam int M_SAME = 3;
    localparam int M_MORE = 4;

    localparam int RESP_WAIT = 8;
    localparam int COUNT_WAIT = 200;
    localparam int FREEZE_WAIT = 60;

    localparam bus_addr_t SRAM_LAST = `SOC_SRAM_BASE + (`SOC_SRAM_DEPTH - 1) * 4;
    localparam bus_addr_t TMR = `SOC_TIMER_BASE;
    localparam bus_addr_t UNMAPPED = 32'h8000_0000;

    logic      clk;
    logic      rst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    bus_addr_t wb_adr;
    bus_data_t wb_dat_w;
    bus_sel_t  wb_sel;
    bus_data_t wb_dat_r;
    logic      wb_ack;
    logic      wb_err;
    logic      dbg_halt;
    logic      timer_irq;

    // Stimulus table with one entry per row in every queue
    int        row_op[$];
    bus_addr_t row_addr[$];
    bus_data_t row_wdata[$];
    bus_sel_t  row_sel[$];
    logic      row_halt[$];
    int        row_cycles[$];
    int        row_mode[$];
    bus_data_t row_lo[$];
    bus_data_t row_hi[$];
    logic      row_err[$];
    logic      row_irq[$];

    int        error_count = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    int        cycle_count = 0;
    int        cycle_limit = 100000;
    int        longest;
    int        errs_before;
    int        lat;
    bus_data_t rd;
    bus_data_t prev_rd;
    logic      r_ack;
    logic      r_err;
    logic      r_irq;

    soc_periph_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .dbg_halt (dbg_halt),
        .timer_irq(timer_irq)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped, cycle limit of %0d reached", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------
    // Table building
    // --------------------

    task automatic add_row(input int op, input bus_addr_t addr, input bus_data_t data,
                           input bus_sel_t sel, input logic halt, input int cycles,
                           input int mode, input bus_data_t lo, input bus_data_t hi,
                           input logic exp_err, input logic exp_irq);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_wdata.push_back(data);
        row_sel.push_back(sel);
        row_halt.push_back(halt);
        row_cycles.push_back(cycles);
        row_mode.push_back(mode);
        row_lo.push_back(lo);
        row_hi.push_back(hi);
        row_err.push_back(exp_err);
        row_irq.push_back(exp_irq);
    endtask

    task automatic add_write(input bus_addr_t addr, input bus_data_t data, input bus_sel_t sel,
                             input logic halt, input logic exp_err, input logic exp_irq);
        add_row(OP_WRITE, addr, data, sel, halt, 0, M_NONE, '0, '0, exp_err, exp_irq);
    endtask

    task automatic add_read(input bus_addr_t addr, input logic halt, input int mode,
                            input bus_data_t lo, input bus_data_t hi,
                            input logic exp_err, input logic exp_irq);
        add_row(OP_READ, addr, '0, 4'hF, halt, 0, mode, lo, hi, exp_err, exp_irq);
    endtask

    task automatic add_idle(input int cycles, input logic halt, input logic exp_irq);
        add_row(OP_IDLE, '0, '0, '0, halt, cycles, M_NONE, '0, '0, 1'b0, exp_irq);
    endtask

    // --------------------
    // Checks and bus access
    // --------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s actual %h expected %h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Latency is counted in falling edges
    // Two of them make one full cycle after the request edge
    task automatic bus_access(input logic write, input bus_addr_t addr, input bus_data_t data,
                              input bus_sel_t sel, output bus_data_t rd_data,
                              output logic resp_ack, output logic resp_err,
                              output logic irq_seen, output int latency);
        int waited;
        waited = 0;
        latency = 0;
        rd_data = '0;
        resp_ack = 1'b0;
        resp_err = 1'b0;
        irq_seen = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = write;
        wb_adr = addr;
        wb_dat_w = data;
        wb_sel = sel;
        while (latency == 0 && waited < RESP_WAIT) begin
            @(negedge clk);
            waited++;
            if (wb_ack || wb_err) begin
                latency = waited;
                rd_data = wb_dat_r;
                resp_ack = wb_ack;
                resp_err = wb_err;
                irq_seen = timer_irq;
            end
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        // Idle cycle between requests
        @(posedge clk);
        #1;
    endtask

    task automatic check_read(input int idx, input bus_data_t data);
        case (row_mode[idx])
            M_EXACT: check_value("wb_dat_r", data, row_lo[idx]);
            M_SAME:  check_value("wb_dat_r", data, prev_rd);
            M_RANGE: begin
                if (data < row_lo[idx] || data > row_hi[idx]) begin
                    $display("Mismatch at %0t ns: wb_dat_r actual %0d expected %0d to %0d",
                             $time, data, row_lo[idx], row_hi[idx]);
                    error_count++;
                end
            end
            M_MORE: begin
                if (data <= prev_rd) begin
                    $display("Mismatch at %0t ns: wb_dat_r actual %0d expected more than %0d",
                             $time, data, prev_rd);
                    error_count++;
                end
            end
            default: ;
        endcase
        prev_rd = data;
    endtask

    function automatic string op_name(input int op);
        case (op)
            OP_WRITE: return "write";
            OP_READ:  return "read ";
            default:  return "idle ";
        endcase
    endfunction

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        dbg_halt = 1'b0;
        prev_rd = '0;

        // Timer state after reset
        add_idle(10, 1'b0, 1'b0);
        add_read(TMR + `SOC_TIMER_MTIME, 0, M_EXACT, 32'h0, 0, 0, 0);
        add_read(TMR + `SOC_TIMER_MTIMECMP, 0, M_EXACT, 32'hFFFF_FFFF, 0, 0, 0);
        add_read(TMR + `SOC_TIMER_MTIMECMPH, 0, M_EXACT, 32'hFFFF_FFFF, 0, 0, 0);
        add_read(TMR + `SOC_TIMER_CTRL, 0, M_EXACT, 32'h0, 0, 0, 0);
        // SRAM byte lanes keep old bytes where sel is clear
        add_write(32'h0000_0010, 32'h1122_3344, 4'b1111, 0, 0, 0);
        add_write(32'h0000_0010, 32'hAABB_CCDD, 4'b0101, 0, 0, 0);
        add_read(32'h0000_0010, 0, M_EXACT, 32'h11BB_33DD, 0, 0, 0);
        add_write(32'h0000_0100, 32'h0102_0304, 4'b1111, 0, 0, 0);
        add_write(32'h0000_0100, 32'hFFFF_FFFF, 4'b0011, 0, 0, 0);
        add_read(32'h0000_0100, 0, M_EXACT, 32'h0102_FFFF, 0, 0, 0);
        add_write(SRAM_LAST, 32'hCAFE_F00D, 4'b1111, 0, 0, 0);
        add_write(SRAM_LAST, 32'h5A5A_5A5A, 4'b1100, 0, 0, 0);
        add_read(SRAM_LAST, 0, M_EXACT, 32'h5A5A_F00D, 0, 0, 0);
        // Unmapped region
        add_read(UNMAPPED, 0, M_EXACT, 32'h0, 0, 1, 0);
        add_write(UNMAPPED + 4, 32'hDEAD_BEEF, 4'b1111, 0, 1, 0);
        add_read(32'h0000_0010, 0, M_EXACT, 32'h11BB_33DD, 0, 0, 0);
        // Counting
        add_write(TMR + `SOC_TIMER_MTIMEH, 32'h1234_5678, 4'b1111, 0, 0, 0);
        add_read(TMR + `SOC_TIMER_MTIMEH, 0, M_EXACT, 32'h1234_5678, 0, 0, 0);
        add_write(TMR + `SOC_TIMER_MTIMEH, 32'h0, 4'b1111, 0, 0, 0);
        add_write(TMR + `SOC_TIMER_MTIME, 32'h0, 4'b1111, 0, 0, 0);
        add_write(TMR + `SOC_TIMER_CTRL, 32'h1, 4'b0001, 0, 0, 0);
        add_read(TMR + `SOC_TIMER_CTRL, 0, M_EXACT, 32'h1, 0, 0, 0);
        add_idle(COUNT_WAIT, 1'b0, 1'b0);
        add_read(TMR + `SOC_TIMER_MTIME, 0, M_RANGE, COUNT_WAIT / `SOC_CLK_MHZ - 2,
                 COUNT_WAIT / `SOC_CLK_MHZ + 2, 0, 0);
        // Interrupt
        add_write(TMR + `SOC_TIMER_MTIMECMPH, 32'h0, 4'b1111, 0, 0, 0);
        add_write(TMR + `SOC_TIMER_MTIMECMP, 32'h2, 4'b1111, 0, 0, 1);
        add_idle(20, 1'b0, 1'b1);
        add_write(TMR + `SOC_TIMER_MTIMECMPH, 32'hFFFF_FFFF, 4'b1111, 0, 0, 0);
        // Debug freeze
        add_idle(4, 1'b1, 1'b0);
        add_read(TMR + `SOC_TIMER_MTIME, 1, M_MORE, 0, 0, 0, 0);
        add_idle(FREEZE_WAIT, 1'b1, 1'b0);
        add_read(TMR + `SOC_TIMER_MTIME, 1, M_SAME, 0, 0, 0, 0);
        add_idle(FREEZE_WAIT, 1'b0, 1'b0);
        add_read(TMR + `SOC_TIMER_MTIME, 0, M_MORE, 0, 0, 0, 0);

        longest = RESP_WAIT;
        foreach (row_cycles[i]) begin
            if (row_cycles[i] > longest) begin
                longest = row_cycles[i];
            end
        end
        cycle_limit = row_op.size() * (longest + 20);

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < row_op.size(); i++) begin
            errs_before = error_count;
            dbg_halt = row_halt[i];
            if (row_op[i] == OP_IDLE) begin
                repeat (row_cycles[i]) @(negedge clk);
                check_value("timer_irq", timer_irq, row_irq[i]);
                @(posedge clk);
                #1;
            end else begin
                bus_access(row_op[i] == OP_WRITE, row_addr[i], row_wdata[i], row_sel[i],
                           rd, r_ack, r_err, r_irq, lat);
                if (lat == 0) begin
                    $display("Row %0d got neither ack nor err within %0d cycles", i, RESP_WAIT);
                    error_count++;
                end else begin
                    check_value("response latency", lat, 2);
                    check_value("wb_ack", r_ack, !row_err[i]);
                    check_value("wb_err", r_err, row_err[i]);
                    check_value("timer_irq", r_irq, row_irq[i]);
                    if (row_op[i] == OP_READ) begin
                        check_read(i, rd);
                    end
                end
            end
            if (error_count == errs_before) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("Row %0d %s %h: %s", i, op_name(row_op[i]), row_addr[i],
                     (error_count == errs_before) ? "ok" : "FAILED");
        end

        $display("Rows passed: %0d, rows failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- soc_periph_top.f
+incdir+source
source/soc_bus_pkg.sv
source/soc_timer_pkg.sv
source/soc_bus_decode.sv
source/soc_sram.sv
source/timer_tick_gen.sv
source/riscv_timer.sv
source/soc_periph_top.sv
bench/tb_soc_periph_top.sv
